// File: logic/fetch_cfg.svh
`ifndef FETCH_CFG_SVH
`define FETCH_CFG_SVH

// ****************************************
// fetch front end build constants
// ****************************************

// first address fetched after reset.
`define FETCH_RESET_PC 32'h1c00_0000

// entries in the direct-mapped BTB, must be a power of two.
`define FETCH_BTB_ENTRIES 16

`endif

// File: logic/fetch_pkg.sv
package fetch_pkg;

    // opcode window of the branch and jump instructions, jirl through bgeu.
    localparam logic [5:0] BR_OP_FIRST = 6'b010011;
    localparam logic [5:0] BR_OP_LAST = 6'b011011;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } btb_predict_t;

    // a branch as resolved by execute.
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
    } br_resolved_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } btb_invalid_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;     // new fetch address.
    } wr_pc_req_t;

    // one accepted cache request and the prediction made for it.
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
    } fetch1_fetch2_pass_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch2_decode_pass_t;

endpackage

// File: logic/bpu.sv
`timescale 1ns/1ns
`include "fetch_cfg.svh"

module bpu import fetch_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [31:0]  lookup_pc_i,
    output btb_predict_t predict_o,
    input  btb_invalid_t btb_invalid_i,
    input  br_resolved_t resolved_i
);

    localparam int ENTRIES = `FETCH_BTB_ENTRIES;
    localparam int IDX_W = $clog2(ENTRIES);
    localparam int TAG_W = 30 - IDX_W;

    typedef struct packed {
        logic [TAG_W-1:0] tag;
        logic [31:0]      target;
    } btb_entry_t;

    logic [ENTRIES-1:0] valid_q;
    btb_entry_t         entry_q [ENTRIES];

    logic [IDX_W-1:0] lk_idx, res_idx, inv_idx;
    logic [TAG_W-1:0] lk_tag, res_tag, inv_tag;
    logic             res_match, inv_en;

    assign lk_idx = lookup_pc_i[IDX_W+1:2];
    assign lk_tag = lookup_pc_i[31:IDX_W+2];
    assign res_idx = resolved_i.pc[IDX_W+1:2];
    assign res_tag = resolved_i.pc[31:IDX_W+2];
    assign inv_idx = btb_invalid_i.pc[IDX_W+1:2];
    assign inv_tag = btb_invalid_i.pc[31:IDX_W+2];

    // ****************************************
    // lookup
    // ****************************************
    assign predict_o.taken = valid_q[lk_idx] && (entry_q[lk_idx].tag == lk_tag);
    assign predict_o.target = entry_q[lk_idx].target;

    // ****************************************
    // training and invalidation
    // ****************************************
    assign res_match = entry_q[res_idx].tag == res_tag;
    // a resolved branch on the same index overrides the invalidate.
    assign inv_en = btb_invalid_i.valid && (entry_q[inv_idx].tag == inv_tag)
                    && !(resolved_i.valid && (res_idx == inv_idx));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            if (inv_en) valid_q[inv_idx] <= 1'b0;
            if (resolved_i.valid) begin
                if (resolved_i.taken) valid_q[res_idx] <= 1'b1;
                else if (res_match) valid_q[res_idx] <= 1'b0;  // not taken drops the entry.
            end
        end
    end

    always_ff @(posedge clk) begin
        if (resolved_i.valid && resolved_i.taken) begin
            entry_q[res_idx] <= '{tag: res_tag, target: resolved_i.target};
        end
    end

endmodule

// File: logic/fetch1.sv
`timescale 1ns/1ns
`include "fetch_cfg.svh"

module fetch1 import fetch_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall_i,

    output logic [31:0]         btb_pc_o,
    input  btb_predict_t        btb_predict_i,

    input  wr_pc_req_t          ex_wr_pc_req_i,
    input  wr_pc_req_t          if2_wr_pc_req_i,

    output logic                icache_req_o,
    output logic [31:0]         icache_pa_o,
    input  logic                icache_ready_i,

    output fetch1_fetch2_pass_t pass_o
);

    logic [31:0] pc_q, pc_d;
    logic        run_q;     // low only until the first edge after reset.
    logic        redirect, accept;

    assign redirect = ex_wr_pc_req_i.valid || if2_wr_pc_req_i.valid;

    // the physical address is the fetch PC itself.
    assign btb_pc_o = pc_q;
    assign icache_pa_o = pc_q;
    assign icache_req_o = run_q && !stall_i && !redirect;
    assign accept = icache_req_o && icache_ready_i;

    // ****************************************
    // next PC selection
    // ****************************************
    always_comb begin
        if (ex_wr_pc_req_i.valid) begin
            pc_d = ex_wr_pc_req_i.pc;
        end else if (if2_wr_pc_req_i.valid) begin
            pc_d = if2_wr_pc_req_i.pc;
        end else if (accept && btb_predict_i.taken) begin
            pc_d = btb_predict_i.target;
        end else if (accept) begin
            pc_d = pc_q + 32'd4;
        end else begin
            pc_d = pc_q;    // wait for the cache to take the request.
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= `FETCH_RESET_PC;
            run_q <= 1'b0;
        end else begin
            pc_q <= pc_d;
            run_q <= 1'b1;
        end
    end

    // the accepted request travels on with the prediction seen for it.
    always_comb begin
        pass_o.valid = accept;
        pass_o.pc = pc_q;
        pass_o.taken = btb_predict_i.taken;
        pass_o.target = btb_predict_i.target;
    end

endmodule

// File: logic/fetch2.sv
`timescale 1ns/1ns

module fetch2 import fetch_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush_i,
    output logic                stall_o,

    input  fetch1_fetch2_pass_t pass_i,

    input  logic [31:0]         icache_data_i,
    input  logic                icache_data_valid_i,
    output logic                icache_data_ready_o,

    output wr_pc_req_t          wr_pc_req_o,
    output btb_invalid_t        btb_invalid_o,

    input  logic                decode_stall_i,
    output logic                decode_valid_o,
    output fetch2_decode_pass_t decode_pass_o
);

    fetch1_fetch2_pass_t pend_q;        // the one request in flight.
    logic                drop_q;        // its response is to be thrown away.
    logic                out_valid_q;
    fetch2_decode_pass_t out_pass_q;

    logic out_hold, take, keep;
    logic is_branch, bad_pred;

    // ****************************************
    // response handshake
    // ****************************************
    assign out_hold = out_valid_q && decode_stall_i;
    assign icache_data_ready_o = pend_q.valid && !out_hold;
    assign take = icache_data_valid_i && icache_data_ready_o;
    assign keep = take && !drop_q && !flush_i;

    // fetch1 may issue again in the cycle the pending response is taken.
    assign stall_o = pend_q.valid && !take;

    // ****************************************
    // pre-decode correction
    // ****************************************
    assign is_branch = (icache_data_i[31:26] >= BR_OP_FIRST)
                       && (icache_data_i[31:26] <= BR_OP_LAST);
    assign bad_pred = keep && pend_q.taken && !is_branch;

    // a taken prediction on a non-branch is undone and the stream resumes at pc+4.
    always_comb begin
        wr_pc_req_o.valid = bad_pred;
        wr_pc_req_o.pc = pend_q.pc + 32'd4;
        btb_invalid_o.valid = bad_pred;
        btb_invalid_o.pc = pend_q.pc;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= '0;
            drop_q <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            if (pass_i.valid) pend_q <= pass_i;
            else if (take) pend_q.valid <= 1'b0;

            if (take) drop_q <= 1'b0;
            else if (flush_i && pend_q.valid) drop_q <= 1'b1;

            if (flush_i) begin
                out_valid_q <= 1'b0;    // the word held for decode is discarded.
            end else if (keep) begin
                out_valid_q <= 1'b1;
            end else if (!decode_stall_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (keep) begin
            out_pass_q <= '{pc: pend_q.pc, inst: icache_data_i};
        end
    end

    assign decode_valid_o = out_valid_q;
    assign decode_pass_o = out_pass_q;

endmodule

// File: logic/fetch_top.sv
`timescale 1ns/1ns

module fetch_top import fetch_pkg::*; (
    input  logic                clk,
    input  logic                rst_n,

    output logic                icache_req_o,
    output logic [31:0]         icache_pa_o,
    input  logic                icache_ready_i,
    input  logic [31:0]         icache_data_i,
    input  logic                icache_data_valid_i,
    output logic                icache_data_ready_o,

    input  br_resolved_t        ex_resolved_i,
    input  wr_pc_req_t          ex_redirect_i,

    input  logic                decode_stall_i,
    output logic                decode_valid_o,
    output fetch2_decode_pass_t decode_pass_o
);

    // ****************************************
    // pass structs and control wiring
    // ****************************************
    fetch1_fetch2_pass_t pass_if1;

    logic [31:0]  pc_if1_to_btb;
    btb_predict_t btb_pre;
    btb_invalid_t if2_btb_invalid;
    wr_pc_req_t   if2_wr_pc_req;

    logic if1_stall_i, if2_stall_o;
    logic if2_flush_i;

    assign if1_stall_i = if2_stall_o;
    assign if2_flush_i = ex_redirect_i.valid;   // only execute flushes fetch2.

    bpu bpu_inst (
        .clk,
        .rst_n,
        .lookup_pc_i   (pc_if1_to_btb),
        .predict_o     (btb_pre),
        .btb_invalid_i (if2_btb_invalid),
        .resolved_i    (ex_resolved_i)
    );

    fetch1 fetch1_inst (
        .clk,
        .rst_n,
        .stall_i         (if1_stall_i),
        .btb_pc_o        (pc_if1_to_btb),
        .btb_predict_i   (btb_pre),
        .ex_wr_pc_req_i  (ex_redirect_i),
        .if2_wr_pc_req_i (if2_wr_pc_req),
        .icache_req_o,
        .icache_pa_o,
        .icache_ready_i,
        .pass_o          (pass_if1)
    );

    fetch2 fetch2_inst (
        .clk,
        .rst_n,
        .flush_i        (if2_flush_i),
        .stall_o        (if2_stall_o),
        .pass_i         (pass_if1),
        .icache_data_i,
        .icache_data_valid_i,
        .icache_data_ready_o,
        .wr_pc_req_o    (if2_wr_pc_req),
        .btb_invalid_o  (if2_btb_invalid),
        .decode_stall_i,
        .decode_valid_o,
        .decode_pass_o
    );

endmodule

// File: tb/fetch_props.sv
`timescale 1ns/1ns

module fetch_props import fetch_pkg::*; (
    input logic                clk,
    input logic                rst_n,
    input logic                icache_req_o,
    input logic                icache_data_ready_o,
    input wr_pc_req_t          ex_redirect_i,
    input wr_pc_req_t          if2_wr_pc_req,
    input logic                decode_stall_i,
    input logic                decode_valid_o,
    input fetch2_decode_pass_t decode_pass_o
);

    // no fetch is issued while the PC is being redirected.
    req_off_on_redirect: assert property (@(posedge clk) disable iff (!rst_n)
        (ex_redirect_i.valid || if2_wr_pc_req.valid) |-> !icache_req_o)
        else $error("cache request during redirect");

    held_word_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (decode_valid_o && decode_stall_i && !ex_redirect_i.valid)
        |=> (decode_valid_o && $stable(decode_pass_o)))
        else $error("decode output changed under stall");

    no_take_under_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !(decode_valid_o && decode_stall_i && icache_data_ready_o))
        else $error("response accepted while decode holds a word");

endmodule

bind fetch_top fetch_props fetch_props_inst (.*);

// File: tb/fetch_tb.sv
`timescale 1ns/1ns
`include "fetch_cfg.svh"

module fetch_tb import fetch_pkg::*; ();

    localparam int IDX_W = $clog2(`FETCH_BTB_ENTRIES);
    localparam logic [31:0] BASE = `FETCH_RESET_PC;
    localparam logic [31:0] BR_PC = BASE + 32'h40;     // a branch word lives here.
    localparam logic [31:0] PLAIN_PC = BASE + 32'h100;  // an ordinary word.

    logic                clk, rst_n;
    logic                icache_req_o, icache_ready_i;
    logic [31:0]         icache_pa_o, icache_data_i;
    logic                icache_data_valid_i, icache_data_ready_o;
    br_resolved_t        ex_resolved_i;
    wr_pc_req_t          ex_redirect_i;
    logic                decode_stall_i, decode_valid_o;
    fetch2_decode_pass_t decode_pass_o;

    logic [31:0] prog_mem [256];
    logic [31:0] rnd, exp_pc, req_addr;
    logic [2:0]  delay_cnt;
    logic        busy, rand_en;
    int          n_words;
    int          n_fixes;

    // reference BTB, full PC kept as the tag.
    logic        m_valid [`FETCH_BTB_ENTRIES];
    logic [31:0] m_pc [`FETCH_BTB_ENTRIES];
    logic [31:0] m_tgt [`FETCH_BTB_ENTRIES];

    fetch_top fetch_top_inst (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic logic is_branch_word(input logic [31:0] w);
        return (w[31:26] >= BR_OP_FIRST) && (w[31:26] <= BR_OP_LAST);
    endfunction

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ****************************************
    // instruction cache model
    // ****************************************
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rnd <= 32'h62c0_5c74;
            busy <= 1'b0;
            delay_cnt <= '0;
            icache_data_valid_i <= 1'b0;
            icache_ready_i <= 1'b0;
            decode_stall_i <= 1'b0;
        end else begin
            rnd <= xorshift(rnd);
            icache_ready_i <= rand_en ? (rnd[3] | rnd[4]) : 1'b1;
            decode_stall_i <= rand_en ? (rnd[7] & rnd[8]) : 1'b0;
            if (icache_data_valid_i && icache_data_ready_o) icache_data_valid_i <= 1'b0;
            if (busy && delay_cnt == 3'd1) begin
                icache_data_valid_i <= 1'b1;
                icache_data_i <= prog_mem[req_addr[9:2]];
                busy <= 1'b0;
            end else if (busy) begin
                delay_cnt <= delay_cnt - 3'd1;
            end
            if (icache_req_o && icache_ready_i) begin
                busy <= 1'b1;
                req_addr <= icache_pa_o;
                delay_cnt <= {1'b0, rnd[12:11]} + 3'd1;     // one to four cycles.
            end
        end
    end

    // ****************************************
    // reference PC stream and checks
    // ****************************************
    always @(posedge clk) begin : monitor
        logic [IDX_W-1:0] idx;
        logic             hit;
        if (rst_n) begin
            if (decode_valid_o && !decode_stall_i && !ex_redirect_i.valid) begin
                assert (decode_pass_o.pc == exp_pc && decode_pass_o.inst
                        == prog_mem[exp_pc[9:2]]) else begin
                    $display("ERROR %0t: got pc %h inst %h, expected pc %h inst %h", $time,
                             decode_pass_o.pc, decode_pass_o.inst, exp_pc,
                             prog_mem[exp_pc[9:2]]);
                    $display("ERRORS FOUND");
                    $fatal(1);
                end
                idx = decode_pass_o.pc[IDX_W+1:2];
                hit = m_valid[idx] && (m_pc[idx] == decode_pass_o.pc);
                if (hit && is_branch_word(decode_pass_o.inst)) begin
                    exp_pc = m_tgt[idx];
                end else begin
                    if (hit) m_valid[idx] = 1'b0;   // pre-decode undoes the prediction.
                    exp_pc = decode_pass_o.pc + 32'd4;
                end
                n_words <= n_words + 1;
            end
            // fetch issues again as a response is taken, unless pre-decode redirects it.
            if (icache_data_valid_i && icache_data_ready_o && !icache_req_o
                && !ex_redirect_i.valid) begin
                n_fixes <= n_fixes + 1;
            end
            if (ex_resolved_i.valid) begin
                idx = ex_resolved_i.pc[IDX_W+1:2];
                if (ex_resolved_i.taken) begin
                    m_valid[idx] = 1'b1;
                    m_pc[idx] = ex_resolved_i.pc;
                    m_tgt[idx] = ex_resolved_i.target;
                end else if (m_pc[idx] == ex_resolved_i.pc) begin
                    m_valid[idx] = 1'b0;
                end
            end
            if (ex_redirect_i.valid) exp_pc = ex_redirect_i.pc;
        end
    end

    task automatic wait_words(input int count);
        int target;
        int t;
        target = n_words + count;
        t = 0;
        while (n_words < target && t < 2000) begin
            @(posedge clk);
            t++;
        end
        if (n_words < target) begin
            $display("timeout: decode did not receive the expected words");
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic send_redirect(input logic [31:0] pc, input br_resolved_t res);
        @(posedge clk);
        ex_redirect_i <= '{valid: 1'b1, pc: pc};
        ex_resolved_i <= res;
        @(posedge clk);
        ex_redirect_i <= '0;
        ex_resolved_i <= '0;
    endtask

    // ****************************************
    // directed tests
    // ****************************************
    task automatic test_reset_stream();
        wait_words(12);
    endtask

    task automatic test_random_backpressure();
        rand_en = 1'b1;
        wait_words(60);
    endtask

    task automatic test_taken_branch();
        send_redirect(BASE + 32'h200, '{valid: 1'b1, pc: BR_PC, taken: 1'b1,
                                        target: BASE + 32'h200});
        wait_words(4);
        send_redirect(BR_PC - 32'd8, '0);
        wait_words(6);     // passes the branch and lands on its target.
    endtask

    task automatic test_redirect_pending();
        int t;
        t = 0;
        while (!busy && t < 200) begin
            @(posedge clk);
            t++;
        end
        if (!busy) begin
            $display("timeout: no cache request became pending");
            $display("ERRORS FOUND");
            $fatal(1);
        end
        ex_redirect_i <= '{valid: 1'b1, pc: BASE + 32'h300};
        @(posedge clk);
        ex_redirect_i <= '0;
        wait_words(3);
    endtask

    task automatic test_false_taken();
        int fixes;
        fixes = n_fixes;
        send_redirect(PLAIN_PC - 32'd8, '{valid: 1'b1, pc: PLAIN_PC, taken: 1'b1,
                                          target: BASE + 32'h180});
        wait_words(5);
        assert (n_fixes == fixes + 1) else begin
            $display("ERROR %0t: %0d pre-decode corrections on the first pass, expected 1",
                     $time, n_fixes - fixes);
            $display("ERRORS FOUND");
            $fatal(1);
        end
        fixes = n_fixes;
        send_redirect(PLAIN_PC - 32'd8, '0);
        wait_words(5);
        assert (n_fixes == fixes) else begin
            $display("ERROR %0t: %0d pre-decode corrections on the second pass, expected 0",
                     $time, n_fixes - fixes);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    endtask

    task automatic test_not_taken();
        // the entry is trained again first, the BTB slot was shared with PLAIN_PC.
        send_redirect(BR_PC - 32'd4, '{valid: 1'b1, pc: BR_PC, taken: 1'b1,
                                       target: BASE + 32'h200});
        wait_words(3);
        send_redirect(BR_PC, '{valid: 1'b1, pc: BR_PC, taken: 1'b0, target: 32'd0});
        wait_words(3);
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            logic [31:0] a;
            a = BASE + 32'(i) * 32'd4;
            prog_mem[i] = {6'b000101, a[27:2] ^ a[31:6]};
        end
        prog_mem[BR_PC[9:2]] = {6'b010110, 26'h0_1234};
        for (int i = 0; i < `FETCH_BTB_ENTRIES; i++) m_valid[i] = 1'b0;
        exp_pc = BASE;
        n_words = 0;
        n_fixes = 0;
        rand_en = 1'b0;
        rst_n = 1'b0;
        icache_ready_i = 1'b0;
        icache_data_valid_i = 1'b0;
        icache_data_i = '0;
        decode_stall_i = 1'b0;
        ex_resolved_i = '0;
        ex_redirect_i = '0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_reset_stream();
        test_random_backpressure();
        test_taken_branch();
        test_redirect_pending();
        test_false_taken();
        test_not_taken();
        repeat (5) @(posedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: fetch_frontend.f
+incdir+logic
logic/fetch_pkg.sv
logic/bpu.sv
logic/fetch1.sv
logic/fetch2.sv
logic/fetch_top.sv
tb/fetch_props.sv
tb/fetch_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module fetch_tb -f fetch_frontend.f

./obj_dir/Vfetch_tb 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
    exit 1
fi
if ! grep -q "NO ERRORS" sim.log; then
    exit 1
fi
exit 0
